// ==== source/posit_format_pkg.sv ====
/*
 * Format constants for posit<16,1> only.
 * Internal widths are sized so that products and the two-term sum stay exact.
 */
`default_nettype none

package posit_format_pkg;

    localparam int posit_width = 16;
    localparam int posit_es = 1;

    // Largest fraction field, reached when the regime is two bits long
    localparam int frac_width = 12;
    localparam int sig_width = frac_width + 1;

    // Operand scale is regime*2 + exponent
    localparam int scale_width = 6;

    // Exact product of two significands, leading one kept at the top
    localparam int prod_sig_width = 2 * sig_width;
    localparam int prod_scale_width = 8;

    // Carry bit, product significand and three guard bits
    localparam int sum_sig_width = prod_sig_width + 4;
    localparam int sum_scale_width = 9;

    localparam logic [posit_width-1:0] nar_pattern = {1'b1, {(posit_width-1){1'b0}}};

    // maxpos is 4^14, minpos is 4^-14
    localparam int max_scale = 28;
    localparam int min_scale = -28;

    localparam int pipe_depth = 6;

endpackage

`default_nettype wire

// ==== source/posit_raw_pkg.sv ====
/*
 * Decoded value bundles passed between pipeline stages.
 * A significand carries its hidden bit in the top position when nonzero.
 */
`default_nettype none

package posit_raw_pkg;

    typedef struct packed {
        logic sgn;
        logic signed [posit_format_pkg::scale_width-1:0] scale;
        logic [posit_format_pkg::sig_width-1:0] sig;
        logic zero;
        logic nar;
    } raw_operand_t;

    // Value is sig * 2^(scale - prod_sig_width + 1)
    typedef struct packed {
        logic sgn;
        logic signed [posit_format_pkg::prod_scale_width-1:0] scale;
        logic [posit_format_pkg::prod_sig_width-1:0] sig;
        logic zero;
        logic nar;
    } raw_product_t;

    // Value is sig * 2^(scale - sum_sig_width + 1), plus a little if sticky
    typedef struct packed {
        logic sgn;
        logic signed [posit_format_pkg::sum_scale_width-1:0] scale;
        logic [posit_format_pkg::sum_sig_width-1:0] sig;
        logic sticky;
        logic zero;
        logic nar;
    } raw_sum_t;

    typedef struct packed {
        logic [posit_format_pkg::posit_width-1:0] a;
        logic [posit_format_pkg::posit_width-1:0] b;
        logic [posit_format_pkg::posit_width-1:0] c;
        logic [posit_format_pkg::posit_width-1:0] d;
    } dot_in_t;

    typedef struct packed {
        logic [posit_format_pkg::posit_width-1:0] result;
    } dot_out_t;

endpackage

`default_nettype wire

// ==== source/posit_decode.sv ====
/*
 * Combinational posit<16,1> decoder, the caller registers the output.
 * Zero and NaR words come out with a cleared significand and scale.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_decode (
    input  wire logic [posit_format_pkg::posit_width-1:0] word,
    output posit_raw_pkg::raw_operand_t                   operand
);

    logic [posit_format_pkg::posit_width-1:0] mag;
    logic [4:0] run;
    logic [14:0] rem;
    logic signed [posit_format_pkg::scale_width-1:0] k;

    always_comb
    begin
        logic go;

        mag = word[15] ? (~word + 16'd1) : word;

        // Length of the regime run starting at bit 14
        run = 5'd1;
        go = 1'b1;
        for (int i = 13; i >= 0; i--)
        begin
            if (go && (mag[i] == mag[14]))
                run = run + 5'd1;
            else
                go = 1'b0;
        end

        k = mag[14] ? (6'(run) - 6'sd1) : -6'(run);

        // Drop the run and its terminating bit
        rem = mag[14:0] << (run + 5'd1);

        operand.sgn = word[15];
        operand.zero = (word == '0);
        operand.nar = (word == posit_format_pkg::nar_pattern);
        if (operand.zero || operand.nar)
        begin
            operand.scale = '0;
            operand.sig = '0;
        end
        else
        begin
            operand.scale = (k <<< 1) + {5'd0, rem[14]};
            operand.sig = {1'b1, rem[13:2]};
        end
    end

    // A real word decodes to a scale between minpos and maxpos
    always_comb
    begin
        if (!operand.zero && !operand.nar)
            assert (operand.scale >= posit_format_pkg::min_scale
                    && operand.scale <= posit_format_pkg::max_scale)
                else $error("posit_decode: scale out of range");
    end

endmodule

`default_nettype wire

// ==== source/posit_mul_raw.sv ====
/*
 * Exact product of two decoded operands, one registered stage.
 * The product significand is left-justified, so no bits are lost.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_mul_raw (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        advance,
    input  posit_raw_pkg::raw_operand_t      a,
    input  posit_raw_pkg::raw_operand_t      b,
    output posit_raw_pkg::raw_product_t      product
);

    logic [posit_format_pkg::prod_sig_width-1:0] full;
    logic signed [posit_format_pkg::prod_scale_width-1:0] scale_sum;

    assign full = a.sig * b.sig;
    assign scale_sum = posit_format_pkg::prod_scale_width'(a.scale)
                     + posit_format_pkg::prod_scale_width'(b.scale);

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            product.sgn <= a.sgn ^ b.sgn;
            product.zero <= a.zero | b.zero;
            product.nar <= a.nar | b.nar;
            // Significand product lies in [1,4)
            if (full[posit_format_pkg::prod_sig_width-1])
            begin
                product.sig <= full;
                product.scale <= scale_sum + 8'sd1;
            end
            else
            begin
                product.sig <= full << 1;
                product.scale <= scale_sum;
            end
        end
    end

    // Nonzero operands always give a left-justified product
    assert property (@(posedge clk) disable iff (!rst_n)
        (advance && !a.zero && !a.nar && !b.zero && !b.nar)
        |=> product.sig[posit_format_pkg::prod_sig_width-1]);

endmodule

`default_nettype wire

// ==== source/posit_add_prod_raw.sv ====
/*
 * Three-stage adder of two exact raw products.
 * Bits lost in alignment fold into sticky, so the result rounds correctly once.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_add_prod_raw (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    advance,
    input  posit_raw_pkg::raw_product_t  p,
    input  posit_raw_pkg::raw_product_t  q,
    output posit_raw_pkg::raw_sum_t      sum
);

    localparam int sw = posit_format_pkg::sum_sig_width;

    // Stage 3, order by magnitude
    posit_raw_pkg::raw_product_t s3_hi, s3_lo;
    logic s3_add;
    logic [7:0] s3_diff;
    logic p_larger;

    always_comb
    begin
        if (q.zero)
            p_larger = 1'b1;
        else if (p.zero)
            p_larger = 1'b0;
        else
            p_larger = (p.scale > q.scale) || ((p.scale == q.scale) && (p.sig >= q.sig));
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            s3_hi <= p_larger ? p : q;
            s3_lo <= p_larger ? q : p;
            s3_add <= (p.sgn == q.sgn);
            // A zero smaller operand may give a wrapped difference, it only shifts zeros
            s3_diff <= p_larger ? 8'(p.scale - q.scale) : 8'(q.scale - p.scale);
        end
    end

    // Stage 4, align and add
    logic [sw-1:0] hi_ext, lo_ext, lo_shift, raw;
    logic lo_sticky;

    always_comb
    begin
        hi_ext = {1'b0, s3_hi.sig, 3'b000};
        lo_ext = {1'b0, s3_lo.sig, 3'b000};
        if (s3_diff >= 8'(sw))
        begin
            lo_shift = '0;
            lo_sticky = |lo_ext;
        end
        else
        begin
            lo_shift = lo_ext >> s3_diff;
            lo_sticky = |(lo_ext & ~({sw{1'b1}} << s3_diff));
        end
        // Borrow the sticky bit so the truncated difference stays below the exact one
        if (s3_add)
            raw = hi_ext + lo_shift;
        else
            raw = hi_ext - lo_shift - {{(sw-1){1'b0}}, lo_sticky};
    end

    logic [sw-1:0] s4_sig;
    logic s4_sticky, s4_sgn, s4_zero, s4_nar;
    logic signed [posit_format_pkg::prod_scale_width-1:0] s4_scale;

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            s4_sig <= raw;
            s4_sticky <= lo_sticky;
            s4_sgn <= s3_hi.sgn;
            s4_scale <= s3_hi.scale;
            s4_zero <= s3_hi.zero;
            s4_nar <= s3_hi.nar | s3_lo.nar;
        end
    end

    // Stage 5, normalize
    logic [4:0] lz;
    logic found;

    always_comb
    begin
        lz = '0;
        found = 1'b0;
        for (int i = sw - 1; i >= 0; i--)
        begin
            if (!found && s4_sig[i])
                found = 1'b1;
            else if (!found)
                lz = lz + 5'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            sum.sgn <= s4_sgn;
            sum.sig <= s4_sig << lz;
            // The carry position sits one above the larger operand's scale
            sum.scale <= posit_format_pkg::sum_scale_width'(s4_scale) + 9'sd1
                       - $signed({4'd0, lz});
            sum.sticky <= s4_sticky;
            sum.zero <= s4_zero | (!found && !s4_sticky);
            sum.nar <= s4_nar;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (!sum.zero && !sum.nar) |-> sum.sig[sw-1]);

endmodule

`default_nettype wire

// ==== source/posit_encode.sv ====
/*
 * Rounds a normalized raw sum to posit<16,1>, nearest with ties to even.
 * Results saturate at minpos and maxpos and never round to zero or NaR.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_encode (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic                                      advance,
    input  posit_raw_pkg::raw_sum_t                        sum,
    output logic [posit_format_pkg::posit_width-1:0]       word
);

    localparam int sw = posit_format_pkg::sum_sig_width;

    logic signed [posit_format_pkg::sum_scale_width-1:0] s, k;
    logic [sw-1:0] body;
    logic [63:0] regime, full;
    logic [14:0] kept, rounded;
    logic guard, rest, clamp;
    int rlen;
    logic [posit_format_pkg::posit_width-1:0] packed_word;

    always_comb
    begin
        clamp = 1'b1;
        if (sum.scale > posit_format_pkg::max_scale)
            s = 9'(posit_format_pkg::max_scale);
        else if (sum.scale < posit_format_pkg::min_scale)
            s = 9'(posit_format_pkg::min_scale);
        else
        begin
            s = sum.scale;
            clamp = 1'b0;
        end

        k = s >>> 1;

        // Exponent bit then the fraction below the hidden bit
        body = clamp ? '0 : {s[0], sum.sig[sw-2:0]};

        if (k >= 0)
        begin
            regime = ~({64{1'b1}} >> (k + 1));
            rlen = int'(k) + 2;
        end
        else
        begin
            regime = 64'h8000_0000_0000_0000 >> (-k);
            rlen = 1 - int'(k);
        end

        full = regime | ({body, {(64-sw){1'b0}}} >> rlen);
        kept = full[63:49];
        guard = full[48];
        rest = (|full[47:0]) | (sum.sticky & !clamp);

        // Never carries past bit 14 since the maxpos string has a zero guard
        rounded = kept + {14'd0, guard & (kept[0] | rest)};

        packed_word = sum.sgn ? (~{1'b0, rounded} + 16'd1) : {1'b0, rounded};
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            if (sum.nar)
                word <= posit_format_pkg::nar_pattern;
            else if (sum.zero)
                word <= '0;
            else
                word <= packed_word;
        end
    end

    // A nonzero real value must not come out as zero or NaR
    assert property (@(posedge clk) disable iff (!rst_n)
        (advance && !sum.zero && !sum.nar)
        |=> (word != '0) && (word != posit_format_pkg::nar_pattern));

endmodule

`default_nettype wire

// ==== source/posit_dot2.sv ====
/*
 * Pipelined a*b + c*d on posit<16,1>, six cycles of latency.
 * All stages advance or stall together, driven by out_ready.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_dot2 (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  posit_raw_pkg::dot_in_t  in_data,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output posit_raw_pkg::dot_out_t out_data
);

    logic [posit_format_pkg::pipe_depth-1:0] valid;
    logic advance;

    posit_raw_pkg::raw_operand_t dec_a, dec_b, dec_c, dec_d;
    posit_raw_pkg::raw_operand_t s1_a, s1_b, s1_c, s1_d;
    posit_raw_pkg::raw_product_t prod_ab, prod_cd;
    posit_raw_pkg::raw_sum_t sum;

    // Move when the output slot is empty or being taken
    assign advance = !valid[posit_format_pkg::pipe_depth-1] || out_ready;
    assign in_ready = advance;
    assign out_valid = valid[posit_format_pkg::pipe_depth-1];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid <= '0;
        else if (advance)
            valid <= {valid[posit_format_pkg::pipe_depth-2:0], in_valid};
    end

    posit_decode dec_a_inst (.word(in_data.a), .operand(dec_a));
    posit_decode dec_b_inst (.word(in_data.b), .operand(dec_b));
    posit_decode dec_c_inst (.word(in_data.c), .operand(dec_c));
    posit_decode dec_d_inst (.word(in_data.d), .operand(dec_d));

    // Stage 1
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            s1_a <= dec_a;
            s1_b <= dec_b;
            s1_c <= dec_c;
            s1_d <= dec_d;
        end
    end

    posit_mul_raw mul_ab_inst (
        .clk(clk), .rst_n(rst_n), .advance(advance),
        .a(s1_a), .b(s1_b), .product(prod_ab)
    );

    posit_mul_raw mul_cd_inst (
        .clk(clk), .rst_n(rst_n), .advance(advance),
        .a(s1_c), .b(s1_d), .product(prod_cd)
    );

    posit_add_prod_raw add_inst (
        .clk(clk), .rst_n(rst_n), .advance(advance),
        .p(prod_ab), .q(prod_cd), .sum(sum)
    );

    posit_encode enc_inst (
        .clk(clk), .rst_n(rst_n), .advance(advance),
        .sum(sum), .word(out_data.result)
    );

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_data));

endmodule

`default_nettype wire

// ==== verif/posit_dot2_tb.sv ====
/*
 * Testbench for posit_dot2 against an exact fixed-point model of a*b + c*d.
 * Model values are integers in units of 2^-120, which holds every product exactly.
 */
`timescale 1ns/1ps
`default_nettype none

module posit_dot2_tb;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    posit_raw_pkg::dot_in_t in_data;
    logic out_valid;
    logic out_ready;
    posit_raw_pkg::dot_out_t out_data;

    int errors;
    int results;
    int cyc;
    logic stall_mode;
    logic check_latency;
    logic stalled;
    logic timed_out;
    logic [15:0] held;

    posit_raw_pkg::dot_in_t sent_q[$];
    logic [15:0] expect_q[$];
    int accept_q[$];
    posit_raw_pkg::dot_in_t mon_x;
    logic [15:0] mon_exp;
    int mon_cyc;

    posit_dot2 posit_dot2_inst (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // Sink takes a result about three cycles in four when stalling
    always @(negedge clk)
        out_ready = stall_mode ? ($urandom % 4 != 0) : 1'b1;

    // Magnitude of an nb-bit posit body (no sign bit), in units of 2^-60
    function automatic logic [255:0] body_value(input logic [15:0] body, input int nb);
        int i;
        int run;
        int k;
        int e;
        int nf;
        logic [255:0] v;
        i = nb - 2;
        run = 1;
        while (i >= 0 && body[i] == body[nb-1])
        begin
            run++;
            i--;
        end
        k = body[nb-1] ? run - 1 : -run;
        // i now points at the regime terminator, or below bit 0
        e = 0;
        if (i >= 1)
            e = int'(body[i-1]);
        nf = (i >= 2) ? i - 1 : 0;
        v = 256'(body & ((16'd1 << nf) - 16'd1));
        v = v | (256'd1 << nf);
        return v << (2 * k + e - nf + 60);
    endfunction

    function automatic logic signed [255:0] posit_value(input logic [15:0] w);
        logic [15:0] mag;
        logic signed [255:0] v;
        if (w == 16'h0000)
            return '0;
        mag = w[15] ? (~w + 16'd1) : w;
        v = signed'(body_value({1'b0, mag[14:0]}, 15));
        return w[15] ? -v : v;
    endfunction

    // Nearest posit in bit-string order, ties to the even word, no zero or NaR
    function automatic logic [14:0] round_magnitude(input logic [255:0] m);
        logic [14:0] lo;
        logic [14:0] hi;
        logic [14:0] mid;
        logic [255:0] half;
        if (m <= (body_value(16'h0001, 15) << 60))
            return 15'h0001;
        if (m >= (body_value(16'h7fff, 15) << 60))
            return 15'h7fff;
        lo = 15'h0001;
        hi = 15'h7fff;
        while (hi - lo > 15'd1)
        begin
            mid = lo + (hi - lo) / 15'd2;
            if ((body_value({1'b0, mid}, 15) << 60) <= m)
                lo = mid;
            else
                hi = mid;
        end
        // Boundary is the one bit longer string of lo followed by a one
        half = body_value({lo, 1'b1}, 16) << 60;
        if (m > half || (m == half && lo[0]))
            return hi;
        return lo;
    endfunction

    function automatic logic [15:0] ref_dot(input posit_raw_pkg::dot_in_t x);
        logic signed [255:0] s;
        logic [14:0] r;
        if (x.a == posit_format_pkg::nar_pattern || x.b == posit_format_pkg::nar_pattern ||
            x.c == posit_format_pkg::nar_pattern || x.d == posit_format_pkg::nar_pattern)
            return posit_format_pkg::nar_pattern;
        s = posit_value(x.a) * posit_value(x.b) + posit_value(x.c) * posit_value(x.d);
        if (s == 0)
            return 16'h0000;
        r = round_magnitude(s < 0 ? -s : s);
        return (s < 0) ? (~{1'b0, r} + 16'd1) : {1'b0, r};
    endfunction

    function automatic posit_raw_pkg::dot_in_t operands(input logic [15:0] a, b, c, d);
        posit_raw_pkg::dot_in_t x;
        x.a = a;
        x.b = b;
        x.c = c;
        x.d = d;
        return x;
    endfunction

    // A timeout counts as an error and skips the remaining stimulus
    task automatic stop_on_timeout(input string why);
        errors++;
        timed_out = 1'b1;
        in_valid = 1'b0;
        $display("%s (time %0t)", why, $time);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input posit_raw_pkg::dot_in_t x, input logic [15:0] expected);
        int waited;
        if (timed_out)
            return;
        waited = 0;
        in_data = x;
        in_valid = 1'b1;
        #1;
        // With the sink always ready the input side never stalls
        if (check_latency && !in_ready)
        begin
            errors++;
            $display("error at %0t: in_ready low while out_ready is high", $time);
        end
        while (!in_ready && waited < 200)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (in_ready)
        begin
            sent_q.push_back(x);
            expect_q.push_back(expected);
            accept_q.push_back(cyc);
            @(negedge clk);
        end
        else
            stop_on_timeout("input was never accepted, in_ready stayed low");
    endtask

    task automatic send_ref(input logic [15:0] a, b, c, d);
        send(operands(a, b, c, d), ref_dot(operands(a, b, c, d)));
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        if (timed_out)
            return;
        waited = 0;
        in_valid = 1'b0;
        while (expect_q.size() > 0 && waited < 1000)
        begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() > 0)
            stop_on_timeout("no result arrived before the timeout");
    endtask

    // Samples just after the falling edge, where handshake and data are settled
    always @(negedge clk)
    begin
        #1;
        if (rst_n)
        begin
            if (stalled && (!out_valid || out_data.result != held))
            begin
                errors++;
                $display("error at %0t: out_data or out_valid changed while stalled", $time);
            end
            stalled = out_valid && !out_ready;
            held = out_data.result;
            if (out_valid && out_ready && expect_q.size() == 0)
            begin
                errors++;
                $display("error at %0t: result %h with nothing expected", $time, held);
            end
            else if (out_valid && out_ready)
            begin
                mon_x = sent_q.pop_front();
                mon_exp = expect_q.pop_front();
                mon_cyc = accept_q.pop_front();
                results++;
                if (out_data.result !== mon_exp)
                begin
                    errors++;
                    $display("error at %0t: got %h, expected %h for a=%h b=%h c=%h d=%h",
                             $time, out_data.result, mon_exp,
                             mon_x.a, mon_x.b, mon_x.c, mon_x.d);
                end
                if (check_latency && cyc - mon_cyc != posit_format_pkg::pipe_depth)
                begin
                    errors++;
                    $display("error at %0t: latency %0d cycles", $time, cyc - mon_cyc);
                end
            end
        end
    end

    initial
    begin
        posit_raw_pkg::dot_in_t x;
        void'($urandom(54319));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        errors = 0;
        results = 0;
        cyc = 0;
        stall_mode = 1'b0;
        check_latency = 1'b0;
        stalled = 1'b0;
        timed_out = 1'b0;
        held = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (!in_ready || out_valid)
        begin
            errors++;
            $display("error at %0t: handshake not idle after reset", $time);
        end
        @(negedge clk);

        // Exact results, cancellation, special values and saturation
        send(operands(16'h4000, 16'h4000, 16'h4000, 16'h4000), 16'h5000);
        send(operands(16'h4800, 16'h5000, 16'h0000, 16'h1234), 16'h5800);
        send(operands(16'h4800, 16'h5000, 16'hb800, 16'h5000), 16'h0000);
        send_ref(16'h4001, 16'h4000, 16'hc000, 16'h4000);
        send_ref(16'h4001, 16'h4001, 16'hc000, 16'h4000);
        send_ref(16'h4001, 16'h4001, 16'h0000, 16'h7fff);
        send(operands(16'h8000, 16'h4000, 16'h4000, 16'h4000), 16'h8000);
        send(operands(16'h4000, 16'h4000, 16'h0000, 16'h8000), 16'h8000);
        send(operands(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff), 16'h7fff);
        send(operands(16'h8001, 16'h7fff, 16'h8001, 16'h7fff), 16'h8001);
        send(operands(16'h0001, 16'h0001, 16'h0000, 16'h0000), 16'h0001);
        send(operands(16'hffff, 16'h0001, 16'h0000, 16'h0000), 16'hffff);
        drain();

        check_latency = 1'b1;
        repeat (2000)
        begin
            x = operands(16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
            send(x, ref_dot(x));
        end
        drain();
        check_latency = 1'b0;

        // Bursty source against a stalling sink
        stall_mode = 1'b1;
        repeat (500)
        begin
            x = operands(16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
            send(x, ref_dot(x));
            if ($urandom % 4 == 0)
                idle(1 + int'($urandom % 3));
        end
        drain();
        stall_mode = 1'b0;

        $display("errors: %0d, results checked: %0d", errors, results);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== posit_dot2.f ====
source/posit_format_pkg.sv
source/posit_raw_pkg.sv
source/posit_decode.sv
source/posit_mul_raw.sv
source/posit_add_prod_raw.sv
source/posit_encode.sv
source/posit_dot2.sv
verif/posit_dot2_tb.sv

// ==== Makefile ====
# Verilator build and run of the posit dot product testbench

TOP := posit_dot2_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into sim.log, check it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f posit_dot2.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Test failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
